// ==== src/axi_slow_pkg.sv ====
`default_nettype none

package axi_slow_pkg;

    localparam int ID_W      = 4;
    localparam int ADDR_W    = 8;   // word address, one word per beat.
    localparam int DATA_W    = 32;
    localparam int LEN_W     = 8;   // holds the beat count minus one.
    localparam int CNT_W     = 9;   // wide enough to reach 256 beats.
    localparam int MEM_WORDS = 256;

    typedef logic [ID_W-1:0]   axi_id_t;
    typedef logic [ADDR_W-1:0] axi_addr_t;
    typedef logic [DATA_W-1:0] axi_data_t;
    typedef logic [LEN_W-1:0]  axi_len_t;
    typedef logic [CNT_W-1:0]  beat_cnt_t;

    // only the okay response exists in this design.
    typedef enum logic [1:0] {
        RESP_OKAY = 2'b00
    } resp_t;

    typedef struct packed {
        axi_id_t   id;
        axi_addr_t addr;
        axi_len_t  len;
    } aw_req_t;

    typedef struct packed {
        axi_id_t   id;
        axi_addr_t addr;
        axi_len_t  len;
    } ar_req_t;

    typedef struct packed {
        axi_data_t data;
        logic      last;
    } w_beat_t;

    typedef struct packed {
        axi_id_t id;
        resp_t   resp;
    } b_resp_t;

    typedef struct packed {
        axi_id_t   id;
        axi_data_t data;
        resp_t     resp;
        logic      last;
    } r_beat_t;

    // state of one address channel throttle.
    typedef enum logic {
        GATE_OPEN = 1'b0,
        GATE_WAIT = 1'b1
    } gate_state_t;

endpackage

`default_nettype wire

// ==== src/burst_beat_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module burst_beat_counter
    import axi_slow_pkg::*;
(
    input  logic     clk,
    input  logic     rstn,
    input  logic     load,
    input  axi_len_t load_len,
    input  logic     beat,
    output logic     burst_done
);

    beat_cnt_t total_q;
    beat_cnt_t count_q;
    beat_cnt_t total;
    beat_cnt_t count_next;

    // a burst that is accepted in this cycle is compared right away.
    assign total = load ? beat_cnt_t'(load_len) + beat_cnt_t'(1) : total_q;

    assign count_next = count_q + beat_cnt_t'(beat);

    assign burst_done = (count_next == total);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            total_q <= '0;
            count_q <= '0;
        end else begin
            if (load) begin
                total_q <= total;
            end
            if (burst_done) begin
                count_q <= '0;  // the next burst starts from zero.
            end else begin
                count_q <= count_next;
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/addr_gate_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module addr_gate_fsm
    import axi_slow_pkg::*;
(
    input  logic clk,
    input  logic rstn,
    input  logic up_valid,
    input  logic down_ready,
    input  logic burst_done,
    output logic down_valid,
    output logic up_ready,
    output logic accepted
);

    gate_state_t state;
    gate_state_t state_next;
    logic        gate_open;

    assign gate_open = (state == GATE_OPEN);

    // both directions are masked so neither side sees a handshake while waiting.
    assign down_valid = gate_open & up_valid;
    assign up_ready   = gate_open & down_ready;
    assign accepted   = up_valid & up_ready;

    always_comb begin
        state_next = state;
        case (state)
            GATE_OPEN: begin
                if (accepted) begin
                    state_next = GATE_WAIT;
                end
            end
            GATE_WAIT: begin
                if (burst_done) begin
                    state_next = GATE_OPEN;  // last beat of the burst was transferred.
                end
            end
            default: begin
                state_next = GATE_OPEN;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= GATE_OPEN;
        end else begin
            state <= state_next;
        end
    end

endmodule

`default_nettype wire

// ==== src/axi_address_slowing.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_address_slowing
    import axi_slow_pkg::*;
(
    input  logic    clk,
    input  logic    rstn,
    input  aw_req_t aw,
    input  logic    aw_valid,
    output logic    aw_ready,
    input  w_beat_t w,
    input  logic    w_valid,
    output logic    w_ready,
    output b_resp_t b,
    output logic    b_valid,
    input  logic    b_ready,
    input  ar_req_t ar,
    input  logic    ar_valid,
    output logic    ar_ready,
    output r_beat_t r,
    output logic    r_valid,
    input  logic    r_ready,
    output aw_req_t m_aw,
    output logic    m_aw_valid,
    input  logic    m_aw_ready,
    output w_beat_t m_w,
    output logic    m_w_valid,
    input  logic    m_w_ready,
    input  b_resp_t m_b,
    input  logic    m_b_valid,
    output logic    m_b_ready,
    output ar_req_t m_ar,
    output logic    m_ar_valid,
    input  logic    m_ar_ready,
    input  r_beat_t m_r,
    input  logic    m_r_valid,
    output logic    m_r_ready
);

    logic aw_accepted;
    logic ar_accepted;
    logic w_done;
    logic r_done;
    logic w_beat;
    logic r_beat;

    assign m_aw = aw;
    assign m_ar = ar;

    assign m_w       = w;
    assign m_w_valid = w_valid;
    assign w_ready   = m_w_ready;

    assign b         = m_b;
    assign b_valid   = m_b_valid;
    assign m_b_ready = b_ready;

    assign r         = m_r;
    assign r_valid   = m_r_valid;
    assign m_r_ready = r_ready;

    assign w_beat = w_valid & w_ready;
    assign r_beat = r_valid & r_ready;

    addr_gate_fsm u_aw_gate (
        .clk        (clk),
        .rstn       (rstn),
        .up_valid   (aw_valid),
        .down_ready (m_aw_ready),
        .burst_done (w_done),
        .down_valid (m_aw_valid),
        .up_ready   (aw_ready),
        .accepted   (aw_accepted)
    );

    burst_beat_counter u_w_counter (
        .clk        (clk),
        .rstn       (rstn),
        .load       (aw_accepted),
        .load_len   (aw.len),
        .beat       (w_beat),
        .burst_done (w_done)
    );

    addr_gate_fsm u_ar_gate (
        .clk        (clk),
        .rstn       (rstn),
        .up_valid   (ar_valid),
        .down_ready (m_ar_ready),
        .burst_done (r_done),
        .down_valid (m_ar_valid),
        .up_ready   (ar_ready),
        .accepted   (ar_accepted)
    );

    burst_beat_counter u_r_counter (
        .clk        (clk),
        .rstn       (rstn),
        .load       (ar_accepted),
        .load_len   (ar.len),
        .beat       (r_beat),
        .burst_done (r_done)
    );

endmodule

`default_nettype wire

// ==== src/axi_burst_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_burst_mem
    import axi_slow_pkg::*;
(
    input  logic    clk,
    input  logic    rstn,
    input  aw_req_t aw,
    input  logic    aw_valid,
    output logic    aw_ready,
    input  w_beat_t w,
    input  logic    w_valid,
    output logic    w_ready,
    output b_resp_t b,
    output logic    b_valid,
    input  logic    b_ready,
    input  ar_req_t ar,
    input  logic    ar_valid,
    output logic    ar_ready,
    output r_beat_t r,
    output logic    r_valid,
    input  logic    r_ready
);

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_DATA,
        WR_RESP
    } wr_state_t;

    typedef enum logic {
        RD_IDLE,
        RD_STREAM
    } rd_state_t;

    axi_data_t mem [MEM_WORDS];

    wr_state_t wr_state;
    axi_id_t   wr_id;
    axi_addr_t wr_addr;
    axi_len_t  wr_left;     // beats still to come after the current one.

    rd_state_t rd_state;
    axi_id_t   rd_id;
    axi_addr_t rd_addr;
    axi_addr_t rd_addr_next;
    axi_len_t  rd_left;
    axi_data_t rd_data;

    logic aw_hs;
    logic w_hs;
    logic b_hs;
    logic ar_hs;
    logic r_hs;

    assign aw_ready = (wr_state == WR_IDLE);
    assign w_ready  = (wr_state == WR_DATA);
    assign b_valid  = (wr_state == WR_RESP);
    assign b        = '{id: wr_id, resp: RESP_OKAY};

    assign ar_ready = (rd_state == RD_IDLE);
    assign r_valid  = (rd_state == RD_STREAM);
    assign r        = '{id: rd_id, data: rd_data, resp: RESP_OKAY, last: (rd_left == '0)};

    assign aw_hs = aw_valid & aw_ready;
    assign w_hs  = w_valid & w_ready;
    assign b_hs  = b_valid & b_ready;
    assign ar_hs = ar_valid & ar_ready;
    assign r_hs  = r_valid & r_ready;

    assign rd_addr_next = rd_addr + axi_addr_t'(1);  // wraps at the top of memory.

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_state <= WR_IDLE;
            wr_left  <= '0;
            rd_state <= RD_IDLE;
            rd_left  <= '0;
        end else begin
            case (wr_state)
                WR_IDLE: begin
                    if (aw_hs) begin
                        wr_left  <= aw.len;
                        wr_state <= WR_DATA;
                    end
                end
                WR_DATA: begin
                    if (w_hs) begin
                        if (wr_left == '0) begin
                            wr_state <= WR_RESP;
                        end else begin
                            wr_left <= wr_left - axi_len_t'(1);
                        end
                    end
                end
                default: begin
                    if (b_hs) begin
                        wr_state <= WR_IDLE;
                    end
                end
            endcase
            if (ar_hs) begin
                rd_left  <= ar.len;
                rd_state <= RD_STREAM;
            end else if (r_hs) begin
                if (rd_left == '0) begin
                    rd_state <= RD_IDLE;
                end else begin
                    rd_left <= rd_left - axi_len_t'(1);
                end
            end
        end
    end

    // the beat on r is registered, so it holds while r_ready is low.
    always_ff @(posedge clk) begin
        if (aw_hs) begin
            wr_id   <= aw.id;
            wr_addr <= aw.addr;
        end else if (w_hs) begin
            mem[wr_addr] <= w.data;
            wr_addr      <= wr_addr + axi_addr_t'(1);
        end
        if (ar_hs) begin
            rd_id   <= ar.id;
            rd_addr <= ar.addr;
            rd_data <= mem[ar.addr];
        end else if (r_hs) begin
            rd_addr <= rd_addr_next;
            rd_data <= mem[rd_addr_next];
        end
    end

endmodule

`default_nettype wire

// ==== src/axi_slow_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_slow_top
    import axi_slow_pkg::*;
(
    input  logic    clk,
    input  logic    rstn,
    input  aw_req_t aw,
    input  logic    aw_valid,
    output logic    aw_ready,
    input  w_beat_t w,
    input  logic    w_valid,
    output logic    w_ready,
    output b_resp_t b,
    output logic    b_valid,
    input  logic    b_ready,
    input  ar_req_t ar,
    input  logic    ar_valid,
    output logic    ar_ready,
    output r_beat_t r,
    output logic    r_valid,
    input  logic    r_ready
);

    aw_req_t m_aw;
    logic    m_aw_valid;
    logic    m_aw_ready;
    w_beat_t m_w;
    logic    m_w_valid;
    logic    m_w_ready;
    b_resp_t m_b;
    logic    m_b_valid;
    logic    m_b_ready;
    ar_req_t m_ar;
    logic    m_ar_valid;
    logic    m_ar_ready;
    r_beat_t m_r;
    logic    m_r_valid;
    logic    m_r_ready;

    axi_address_slowing u_slowing (
        .clk        (clk),
        .rstn       (rstn),
        .aw         (aw),         .aw_valid   (aw_valid),   .aw_ready   (aw_ready),
        .w          (w),          .w_valid    (w_valid),    .w_ready    (w_ready),
        .b          (b),          .b_valid    (b_valid),    .b_ready    (b_ready),
        .ar         (ar),         .ar_valid   (ar_valid),   .ar_ready   (ar_ready),
        .r          (r),          .r_valid    (r_valid),    .r_ready    (r_ready),
        .m_aw       (m_aw),       .m_aw_valid (m_aw_valid), .m_aw_ready (m_aw_ready),
        .m_w        (m_w),        .m_w_valid  (m_w_valid),  .m_w_ready  (m_w_ready),
        .m_b        (m_b),        .m_b_valid  (m_b_valid),  .m_b_ready  (m_b_ready),
        .m_ar       (m_ar),       .m_ar_valid (m_ar_valid), .m_ar_ready (m_ar_ready),
        .m_r        (m_r),        .m_r_valid  (m_r_valid),  .m_r_ready  (m_r_ready)
    );

    axi_burst_mem u_mem (
        .clk      (clk),
        .rstn     (rstn),
        .aw       (m_aw),   .aw_valid (m_aw_valid), .aw_ready (m_aw_ready),
        .w        (m_w),    .w_valid  (m_w_valid),  .w_ready  (m_w_ready),
        .b        (m_b),    .b_valid  (m_b_valid),  .b_ready  (m_b_ready),
        .ar       (m_ar),   .ar_valid (m_ar_valid), .ar_ready (m_ar_ready),
        .r        (m_r),    .r_valid  (m_r_valid),  .r_ready  (m_r_ready)
    );

endmodule

`default_nettype wire

// ==== sim/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rstn
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;  // 100 ns period.
    end

    initial begin
        rstn = 1'b0;
        repeat (10) @(posedge clk);
        #10;
        rstn = 1'b1;  // released just after an edge, like the other stimulus.
    end

endmodule

`default_nettype wire

// ==== sim/axi_slow_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_slow_props
    import axi_slow_pkg::*;
(
    input logic        clk,
    input logic        rstn,
    input logic        aw_valid,
    input logic        aw_ready,
    input logic        m_aw_valid,
    input logic        w_valid,
    input logic        w_ready,
    input logic        ar_valid,
    input logic        ar_ready,
    input logic        m_ar_valid,
    input logic        r_valid,
    input logic        r_ready,
    input gate_state_t aw_state,
    input gate_state_t ar_state
);

    int unsigned fail_count = 0;  // read by the testbench at the end of the run.

    a_aw_closed: assert property (@(posedge clk) disable iff (!rstn)
        (aw_state == GATE_WAIT) |-> !(aw_valid && aw_ready) && !m_aw_valid)
        else begin
            $error("write address handshake while the AW gate is waiting");
            fail_count++;
        end

    a_aw_reopen: assert property (@(posedge clk) disable iff (!rstn)
        (aw_state == GATE_WAIT) && !(w_valid && w_ready) |=> (aw_state == GATE_WAIT))
        else begin
            $error("AW gate reopened without a W handshake");
            fail_count++;
        end

    a_ar_closed: assert property (@(posedge clk) disable iff (!rstn)
        (ar_state == GATE_WAIT) |-> !(ar_valid && ar_ready) && !m_ar_valid)
        else begin
            $error("read address handshake while the AR gate is waiting");
            fail_count++;
        end

    a_ar_reopen: assert property (@(posedge clk) disable iff (!rstn)
        (ar_state == GATE_WAIT) && !(r_valid && r_ready) |=> (ar_state == GATE_WAIT))
        else begin
            $error("AR gate reopened without an R handshake");
            fail_count++;
        end

endmodule

bind axi_address_slowing axi_slow_props u_props (
    .clk        (clk),
    .rstn       (rstn),
    .aw_valid   (aw_valid),
    .aw_ready   (aw_ready),
    .m_aw_valid (m_aw_valid),
    .w_valid    (w_valid),
    .w_ready    (w_ready),
    .ar_valid   (ar_valid),
    .ar_ready   (ar_ready),
    .m_ar_valid (m_ar_valid),
    .r_valid    (r_valid),
    .r_ready    (r_ready),
    .aw_state   (u_aw_gate.state),
    .ar_state   (u_ar_gate.state)
);

`default_nettype wire

// ==== sim/tb_axi_slow.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_axi_slow
    import axi_slow_pkg::*;
();

    localparam int          PER_ROUND   = 4;
    localparam int          N_ROUNDS    = 10;
    localparam int          FILL_BURSTS = MEM_WORDS / 16;
    localparam int          WATCHDOG_NS = 80 * 40 * 100;  // 80 bursts of 40 cycles each.
    localparam logic [31:0] SEED        = 32'hc273_31ad;

    logic    clk;
    logic    rstn;
    aw_req_t aw;
    logic    aw_valid;
    logic    aw_ready;
    w_beat_t w;
    logic    w_valid;
    logic    w_ready;
    b_resp_t b;
    logic    b_valid;
    logic    b_ready;
    ar_req_t ar;
    logic    ar_valid;
    logic    ar_ready;
    r_beat_t r;
    logic    r_valid;
    logic    r_ready;

    logic aw_hs;
    logic w_hs;
    logic b_hs;
    logic ar_hs;
    logic r_hs;

    axi_data_t ref_mem [MEM_WORDS];
    logic      w_busy;
    logic      b_pending;
    axi_len_t  w_len_q;
    beat_cnt_t w_cnt;
    axi_addr_t w_addr_q;
    axi_id_t   b_id_q;
    int        b_count;
    logic      r_busy;
    axi_len_t  r_len_q;
    beat_cnt_t r_cnt;
    axi_addr_t r_addr_q;
    axi_id_t   r_id_q;
    int        r_done_count;

    int        writes_expected = 0;
    int        reads_expected  = 0;
    int        mismatches      = 0;
    int        other_errors    = 0;
    axi_addr_t recent_addr [$];

    tb_clock_gen u_clock_gen (
        .clk  (clk),
        .rstn (rstn)
    );

    axi_slow_top i_axi_slow_top (.*);

    assign aw_hs = aw_valid & aw_ready;
    assign w_hs  = w_valid & w_ready;
    assign b_hs  = b_valid & b_ready;
    assign ar_hs = ar_valid & ar_ready;
    assign r_hs  = r_valid & r_ready;

    // reference model of the memory and of the burst in flight on each side.
    always @(posedge clk) begin
        if (!rstn) begin
            w_busy       <= 1'b0;
            b_pending    <= 1'b0;
            w_cnt        <= '0;
            b_count      <= 0;
            r_busy       <= 1'b0;
            r_cnt        <= '0;
            r_done_count <= 0;
        end else begin
            if (aw_hs) begin
                w_busy   <= 1'b1;
                w_len_q  <= aw.len;
                w_cnt    <= '0;
                w_addr_q <= aw.addr;
                b_id_q   <= aw.id;
            end
            if (w_hs) begin
                ref_mem[w_addr_q] <= w.data;
                w_addr_q          <= w_addr_q + 1'b1;  // wraps with the 8-bit address.
                w_cnt             <= w_cnt + 1'b1;
                if (w_cnt == beat_cnt_t'(w_len_q)) begin
                    w_busy    <= 1'b0;
                    b_pending <= 1'b1;
                end
            end
            if (b_hs) begin
                b_pending <= 1'b0;
                b_count   <= b_count + 1;
            end
            if (ar_hs) begin
                r_busy   <= 1'b1;
                r_len_q  <= ar.len;
                r_cnt    <= '0;
                r_addr_q <= ar.addr;
                r_id_q   <= ar.id;
            end
            if (r_hs) begin
                r_addr_q <= r_addr_q + 1'b1;
                r_cnt    <= r_cnt + 1'b1;
                if (r_cnt == beat_cnt_t'(r_len_q)) begin
                    r_busy       <= 1'b0;
                    r_done_count <= r_done_count + 1;
                end
            end
        end
    end

    task automatic report_mismatch(input string test, input logic [31:0] expected,
                                   input logic [31:0] actual);
        mismatches++;
        $display("MISMATCH %s: expected %0h, actual %0h", test, expected, actual);
    endtask

    task automatic report_error(input string what);
        other_errors++;
        $display("ERROR: %s", what);
    endtask

    a_aw_throttle: assert property (@(posedge clk) disable iff (!rstn) aw_hs |-> !w_busy)
        else report_error("write address accepted before the last W beat of the burst");
    a_ar_throttle: assert property (@(posedge clk) disable iff (!rstn) ar_hs |-> !r_busy)
        else report_error("read address accepted before the last R beat of the burst");
    a_read_data: assert property (@(posedge clk) disable iff (!rstn)
        r_hs |-> (r.data == ref_mem[r_addr_q]))
        else report_mismatch("read_data", $sampled(ref_mem[r_addr_q]), $sampled(r.data));
    a_read_last: assert property (@(posedge clk) disable iff (!rstn)
        r_hs |-> (r.last == (r_cnt == beat_cnt_t'(r_len_q))))
        else report_mismatch("read_last", $sampled(r_cnt == beat_cnt_t'(r_len_q)),
                             $sampled(r.last));
    a_read_id: assert property (@(posedge clk) disable iff (!rstn) r_hs |-> (r.id == r_id_q))
        else report_mismatch("read_id", $sampled(r_id_q), $sampled(r.id));
    a_read_resp: assert property (@(posedge clk) disable iff (!rstn)
        r_hs |-> (r.resp == RESP_OKAY))
        else report_mismatch("read_resp", RESP_OKAY, $sampled(r.resp));
    a_read_owner: assert property (@(posedge clk) disable iff (!rstn) r_valid |-> r_busy)
        else report_error("R beat presented with no read burst outstanding");
    a_w_owner: assert property (@(posedge clk) disable iff (!rstn) w_hs |-> w_busy)
        else report_error("W beat accepted with no write burst outstanding");
    a_b_owner: assert property (@(posedge clk) disable iff (!rstn) b_valid |-> b_pending)
        else report_error("B response without a finished write burst waiting for it");
    a_b_id: assert property (@(posedge clk) disable iff (!rstn) b_hs |-> (b.id == b_id_q))
        else report_mismatch("write_id", $sampled(b_id_q), $sampled(b.id));
    a_b_resp: assert property (@(posedge clk) disable iff (!rstn)
        b_hs |-> (b.resp == RESP_OKAY))
        else report_mismatch("write_resp", RESP_OKAY, $sampled(b.resp));
    a_r_hold: assert property (@(posedge clk) disable iff (!rstn)
        r_valid && !r_ready |=> r_valid && $stable(r))
        else report_error("R beat changed while r_ready was low");
    a_b_hold: assert property (@(posedge clk) disable iff (!rstn)
        b_valid && !b_ready |=> b_valid && $stable(b))
        else report_error("B response changed while b_ready was low");
    a_reset_idle: assert property (@(posedge clk)
        $rose(rstn) |-> !b_valid && !r_valid && aw_ready && ar_ready)
        else report_error("DUT not idle and ready right after reset");

    function automatic axi_data_t fill_word(input axi_addr_t a);
        return {a, ~a, a ^ 8'h3c, a[3:0], a[7:4]};
    endfunction

    function automatic int pick_gap();
        return ($urandom % 2) ? 0 : int'($urandom % 4);  // zero gaps give back-to-back bursts.
    endfunction

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #10;
        end
    endtask

    task automatic send_aw(input aw_req_t req);
        aw       = req;
        aw_valid = 1'b1;
        do @(posedge clk); while (!aw_ready);
        #10;
        aw_valid = 1'b0;
    endtask

    task automatic send_ar(input ar_req_t req);
        ar       = req;
        ar_valid = 1'b1;
        do @(posedge clk); while (!ar_ready);
        #10;
        ar_valid = 1'b0;
    endtask

    task automatic send_w_burst(input aw_req_t req, input bit fill);
        axi_addr_t addr;
        addr = req.addr;
        for (int k = 0; k <= int'(req.len); k++) begin
            if (!fill && ($urandom % 4 == 0)) begin
                idle_cycles(1);
            end
            w.data  = fill ? fill_word(addr) : axi_data_t'($urandom);
            w.last  = (k == int'(req.len));
            w_valid = 1'b1;
            do @(posedge clk); while (!w_ready);
            #10;
            w_valid = 1'b0;
            addr    = addr + 1'b1;
        end
    endtask

    // addresses and data run in parallel so the next AW waits on the gate.
    task automatic write_round(input int n, input bit fill, input int first);
        aw_req_t reqs [$];
        aw_req_t req;
        for (int i = 0; i < n; i++) begin
            req.id = axi_id_t'($urandom);
            if (fill) begin
                req.addr = axi_addr_t'((first + i) * 16);
                req.len  = axi_len_t'(15);
            end else begin
                req.addr = ($urandom % 4 == 0) ? (8'hf0 | axi_addr_t'($urandom % 16))
                                               : axi_addr_t'($urandom);
                req.len  = axi_len_t'($urandom_range(15, 0));
                recent_addr.push_back(req.addr);
                if (recent_addr.size() > 8) begin
                    void'(recent_addr.pop_front());
                end
            end
            reqs.push_back(req);
        end
        writes_expected += n;
        fork
            begin
                foreach (reqs[i]) begin
                    idle_cycles(fill ? 0 : pick_gap());
                    send_aw(reqs[i]);
                end
            end
            begin
                foreach (reqs[i]) begin
                    send_w_burst(reqs[i], fill);
                end
            end
        join
        wait (b_count == writes_expected);
        #10;
    endtask

    task automatic read_round(input int n);
        ar_req_t req;
        int      sel;
        for (int i = 0; i < n; i++) begin
            sel     = $urandom % 4;
            req.id  = axi_id_t'($urandom);
            req.len = axi_len_t'($urandom_range(15, 0));
            if (sel == 0 && recent_addr.size() > 0) begin
                req.addr = recent_addr[$urandom % recent_addr.size()];
            end else if (sel == 1) begin
                req.addr = 8'hf0 | axi_addr_t'($urandom % 16);  // likely to wrap.
            end else begin
                req.addr = axi_addr_t'($urandom);
            end
            idle_cycles(pick_gap());
            send_ar(req);
            reads_expected++;
        end
        wait (r_done_count == reads_expected);
        #10;
    endtask

    initial begin
        wait (rstn === 1'b1);
        forever begin
            b_ready = ($urandom % 4) != 0;
            r_ready = ($urandom % 4) != 0;
            @(posedge clk);
            #10;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("TIMEOUT: tests still running after %0d ns, a handshake never finished",
                 WATCHDOG_NS);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        int unsigned prop_errors;
        void'($urandom(SEED));
        aw         = '0;
        aw_valid   = 1'b0;
        w          = '0;
        w_valid    = 1'b0;
        b_ready    = 1'b0;
        ar         = '0;
        ar_valid   = 1'b0;
        r_ready    = 1'b0;
        wait (rstn === 1'b1);
        for (int i = 0; i < FILL_BURSTS; i += PER_ROUND) begin
            write_round(PER_ROUND, 1'b1, i);
        end
        for (int round = 0; round < N_ROUNDS; round++) begin
            write_round(PER_ROUND, 1'b0, 0);
            read_round(PER_ROUND);
        end
        idle_cycles(5);
        prop_errors = i_axi_slow_top.u_slowing.u_props.fail_count;
        $display("summary: %0d mismatches, %0d other errors, %0d gate assertion failures",
                 mismatches, other_errors, prop_errors);
        if (mismatches == 0 && other_errors == 0 && prop_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
src/axi_slow_pkg.sv
src/burst_beat_counter.sv
src/addr_gate_fsm.sv
src/axi_address_slowing.sv
src/axi_burst_mem.sv
src/axi_slow_top.sv
sim/tb_clock_gen.sv
sim/axi_slow_props.sv
sim/tb_axi_slow.sv

// ==== Bender.yml ====
package:
  name: axi_slow

sources:
  - src/axi_slow_pkg.sv
  - src/burst_beat_counter.sv
  - src/addr_gate_fsm.sv
  - src/axi_address_slowing.sv
  - src/axi_burst_mem.sv
  - src/axi_slow_top.sv
  - target: simulation
    files:
      - sim/tb_clock_gen.sv
      - sim/axi_slow_props.sv
      - sim/tb_axi_slow.sv
